// ==== common/icache_pkg.sv ====
package icache_pkg;

    ////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////
    localparam int INDEX_W  = 7;
    localparam int TAG_W    = 20;
    localparam int WORD_W   = 32;
    localparam int HALF_W   = 128;
    localparam int BEATS    = 8;
    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 128;

    // controller states
    typedef enum logic [2:0] {
        st_reset,
        st_idle,
        st_run,
        st_miss,
        st_refill,
        st_finish,
        st_recover
    } icache_state_e;

    // refill fills by word, hits read by half
    typedef union packed {
        logic [BEATS-1:0][WORD_W-1:0] words;
        logic [1:0][HALF_W-1:0]       halves;
    } icache_line_u;

    // one request in flight
    typedef struct packed {
        logic               valid;
        logic [INDEX_W-1:0] index;
        logic               half;
        logic [TAG_W-1:0]   tag;
        logic               exc;
    } icache_req_t;

    // line assembled by the refill unit
    typedef struct packed {
        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   tag;
        icache_line_u       line;
    } icache_fill_t;

    // strobes from the controller, one per state of interest
    typedef struct packed {
        logic run;
        logic miss_detect;
        logic miss_start;
        logic refilling;
        logic write_line;
        logic recapture;
        logic sweep;
    } icache_ctrl_t;

endpackage

// ==== icache/icache_way_ram.sv ====
module icache_way_ram (
    input  logic                              clk,
    input  logic [icache_pkg::INDEX_W-1:0]    rd_index,
    input  logic                              wen,
    input  logic [icache_pkg::INDEX_W-1:0]    wr_index,
    input  logic [icache_pkg::TAG_W-1:0]      wr_tag,
    input  logic                              wr_valid,
    input  icache_pkg::icache_line_u          wr_line,
    output logic [icache_pkg::TAG_W:0]        rd_tagv,
    output icache_pkg::icache_line_u          rd_line
);
    import icache_pkg::*;

    // tag in the upper bits, valid in bit 0
    logic [TAG_W:0] tagv_mem [NUM_SETS];
    icache_line_u   line_mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (wen) begin
            tagv_mem[wr_index] <= {wr_tag, wr_valid};
        end
        // invalidation leaves the data alone
        if (wen && wr_valid) begin
            line_mem[wr_index] <= wr_line;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        rd_tagv <= tagv_mem[rd_index];
        rd_line <= line_mem[rd_index];
    end

endmodule

// ==== icache/icache_lru.sv ====
module icache_lru (
    input  logic                              clk,
    input  logic                              rst,
    input  icache_pkg::icache_ctrl_t          ctrl,
    input  logic [icache_pkg::INDEX_W-1:0]    index,
    output logic [icache_pkg::NUM_WAYS-1:0]   victim
);
    import icache_pkg::*;

    // one bit per set, names the next way to replace
    logic [NUM_SETS-1:0] plru;

    ////////////////////////////////////////////////////////////
    // victim choice and update
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            plru   <= '0;
            victim <= '0;
        end else begin
            // 0 selects way 0, 1 selects way 1
            if (ctrl.miss_detect) begin
                victim <= NUM_WAYS'(1) << plru[index];
            end
            // point away from the way being filled
            if (ctrl.miss_start) begin
                plru[index] <= victim[0];
            end
        end
    end

endmodule

// ==== icache/icache_refill.sv ====
module icache_refill #(
    parameter logic [3:0] AXI_ID = 4'h0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  icache_pkg::icache_ctrl_t   ctrl,
    input  icache_pkg::icache_req_t    sda,
    input  logic                       arready,
    input  logic [3:0]                 rid,
    input  logic [31:0]                rdata,
    input  logic                       rlast,
    input  logic                       rvalid,
    output logic [31:0]                araddr,
    output logic                       arvalid,
    output logic                       rready,
    output icache_pkg::icache_fill_t   fill,
    output logic                       fill_done
);
    import icache_pkg::*;

    localparam int CNT_W = $clog2(BEATS);

    logic [CNT_W-1:0] beat_cnt;
    logic             addr_hs;
    logic             beat_ok;

    ////////////////////////////////////////////////////////////
    // AXI read, slave assumes 8 beats of 4 bytes, wrapping
    ////////////////////////////////////////////////////////////
    assign arvalid = ctrl.miss_start;
    // requested half first, low bits zero
    assign araddr  = {sda.tag, sda.index, sda.half, 4'b0000};
    assign rready  = ctrl.refilling;

    assign addr_hs   = ctrl.miss_start && arready;
    // beats for other ids are ignored
    assign beat_ok   = ctrl.refilling && rvalid && (rid == AXI_ID);
    assign fill_done = beat_ok && rlast;

    // wrap follows the burst order, starting at the requested half
    always_ff @(posedge clk) begin
        if (!rst) begin
            beat_cnt <= '0;
        end else if (addr_hs) begin
            beat_cnt <= {sda.half, {(CNT_W - 1){1'b0}}};
        end else if (beat_ok) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // line buffer
    always_ff @(posedge clk) begin
        if (addr_hs) begin
            fill.index <= sda.index;
            fill.tag   <= sda.tag;
        end
        if (beat_ok) begin
            fill.line.words[beat_cnt] <= rdata;
        end
    end

endmodule

// ==== icache/icache_pipe.sv ====
module icache_pipe (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              inst_req,
    input  logic [icache_pkg::INDEX_W:0]      inst_index,
    input  logic [icache_pkg::TAG_W-1:0]      inst_tag,
    input  logic                              inst_exc,
    input  icache_pkg::icache_ctrl_t          ctrl,
    input  logic [icache_pkg::TAG_W:0]        rd_tagv0,
    input  logic [icache_pkg::TAG_W:0]        rd_tagv1,
    input  icache_pkg::icache_line_u          rd_line0,
    input  icache_pkg::icache_line_u          rd_line1,
    output logic                              inst_index_ok,
    output logic                              inst_data_ok,
    output logic [icache_pkg::HALF_W-1:0]     inst_rdata,
    output logic [icache_pkg::INDEX_W-1:0]    rd_index,
    output icache_pkg::icache_req_t           sda,
    output logic                              sda_miss
);
    import icache_pkg::*;

    icache_req_t         sin;
    icache_req_t         sta_q;
    icache_req_t         sta;
    logic [TAG_W:0]      sda_tagv0;
    logic [TAG_W:0]      sda_tagv1;
    icache_line_u        sda_line0;
    icache_line_u        sda_line1;
    icache_line_u        hit_line;
    logic [NUM_WAYS-1:0] hit_way;
    logic                hit_run;
    logic                advance;

    // index stage, tag and exc follow a cycle later
    always_comb begin
        sin.valid = inst_req;
        sin.index = inst_index[INDEX_W:1];
        sin.half  = inst_index[0];
        sin.tag   = '0;
        sin.exc   = 1'b0;
    end

    always_comb begin
        sta     = sta_q;
        sta.tag = inst_tag;
        sta.exc = inst_exc;
    end

    // data stage moves when empty or completing
    assign advance       = inst_data_ok || !sda.valid;
    assign inst_index_ok = ctrl.run && inst_req && advance;

    ////////////////////////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            sta_q.valid <= 1'b0;
        end else if (inst_index_ok) begin
            sta_q <= sin;
        end else if (advance) begin
            sta_q.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            sda.valid <= 1'b0;
        end else if (advance) begin
            sda <= sta;
        end
    end

    // recapture picks up the line written during the miss
    always_ff @(posedge clk) begin
        if (advance || ctrl.recapture) begin
            sda_tagv0 <= rd_tagv0;
            sda_tagv1 <= rd_tagv1;
            sda_line0 <= rd_line0;
            sda_line1 <= rd_line1;
        end
    end

    // read the next stage while running, else the one being held
    assign rd_index = ctrl.run       ? sin.index   :
                      ctrl.recapture ? sta_q.index : sda.index;

    ////////////////////////////////////////////////////////////
    // hit and completion
    ////////////////////////////////////////////////////////////
    assign hit_way[0] = sda_tagv0[0] && (sda_tagv0[TAG_W:1] == sda.tag);
    assign hit_way[1] = sda_tagv1[0] && (sda_tagv1[TAG_W:1] == sda.tag);
    assign hit_run    = ctrl.run && (|hit_way);

    assign inst_data_ok = sda.valid && (hit_run || sda.exc);
    assign sda_miss     = ctrl.run && sda.valid && !(|hit_way) && !sda.exc;

    assign hit_line   = hit_way[1] ? sda_line1 : sda_line0;
    assign inst_rdata = hit_line.halves[sda.half];

endmodule

// ==== icache/icache_ctrl.sv ====
module icache_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              sda_miss,
    input  logic                              fill_done,
    input  logic                              arready,
    input  logic [icache_pkg::NUM_WAYS-1:0]   victim,
    input  icache_pkg::icache_fill_t          fill,
    output icache_pkg::icache_ctrl_t          ctrl,
    output logic [icache_pkg::NUM_WAYS-1:0]   way_wen,
    output logic [icache_pkg::INDEX_W-1:0]    wr_index,
    output logic [icache_pkg::TAG_W-1:0]      wr_tag,
    output logic                              wr_valid
);
    import icache_pkg::*;

    icache_state_e      state;
    icache_state_e      state_next;
    logic [INDEX_W-1:0] sweep_cnt;

    ////////////////////////////////////////////////////////////
    // main FSM
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            st_reset:   if (sweep_cnt == INDEX_W'(NUM_SETS - 1)) state_next = st_idle;
            st_idle:    state_next = st_run;
            st_run:     if (sda_miss) state_next = st_miss;
            // address phase until the slave takes it
            st_miss:    if (arready) state_next = st_refill;
            st_refill:  if (fill_done) state_next = st_finish;
            st_finish:  state_next = st_recover;
            // recover re-reads the new line, idle lands it in the data stage
            st_recover: state_next = st_idle;
            default:    state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_reset;
        end else begin
            state <= state_next;
        end
    end

    // one set invalidated per sweep cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            sweep_cnt <= '0;
        end else if (state == st_reset) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // strobes and way writes
    ////////////////////////////////////////////////////////////
    always_comb begin
        ctrl.run         = (state == st_run);
        ctrl.miss_detect = (state == st_run) && sda_miss;
        ctrl.miss_start  = (state == st_miss);
        ctrl.refilling   = (state == st_refill);
        ctrl.write_line  = (state == st_finish);
        ctrl.recapture   = (state == st_idle);
        ctrl.sweep       = (state == st_reset);
    end

    always_comb begin
        case (state)
            st_reset:  way_wen = '1;
            st_finish: way_wen = victim;
            default:   way_wen = '0;
        endcase
    end

    assign wr_index = ctrl.sweep ? sweep_cnt : fill.index;
    assign wr_tag   = fill.tag;
    // sweep writes an invalid entry, finish a valid one
    assign wr_valid = ctrl.write_line;

endmodule

// ==== icache/icache_top.sv ====
module icache_top #(
    parameter logic [3:0] AXI_ID = 4'h0
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             inst_req,
    input  logic [icache_pkg::INDEX_W:0]     inst_index,
    input  logic [icache_pkg::TAG_W-1:0]     inst_tag,
    input  logic                             inst_exc,
    output logic [icache_pkg::HALF_W-1:0]    inst_rdata,
    output logic                             inst_index_ok,
    output logic                             inst_data_ok,
    output logic [31:0]                      araddr,
    output logic                             arvalid,
    input  logic                             arready,
    input  logic [3:0]                       rid,
    input  logic [31:0]                      rdata,
    input  logic                             rlast,
    input  logic                             rvalid,
    output logic                             rready
);
    import icache_pkg::*;

    icache_ctrl_t          ctrl;
    icache_req_t           sda;
    icache_fill_t          fill;
    logic                  sda_miss;
    logic                  fill_done;
    logic [NUM_WAYS-1:0]   victim;
    logic [NUM_WAYS-1:0]   way_wen;
    logic [INDEX_W-1:0]    wr_index;
    logic [INDEX_W-1:0]    rd_index;
    logic [TAG_W-1:0]      wr_tag;
    logic                  wr_valid;
    logic [TAG_W:0]        rd_tagv0;
    logic [TAG_W:0]        rd_tagv1;
    icache_line_u          rd_line0;
    icache_line_u          rd_line1;

    icache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .sda_miss  (sda_miss),
        .fill_done (fill_done),
        .arready   (arready),
        .victim    (victim),
        .fill      (fill),
        .ctrl      (ctrl),
        .way_wen   (way_wen),
        .wr_index  (wr_index),
        .wr_tag    (wr_tag),
        .wr_valid  (wr_valid)
    );

    icache_pipe u_pipe (
        .clk           (clk),
        .rst           (rst),
        .inst_req      (inst_req),
        .inst_index    (inst_index),
        .inst_tag      (inst_tag),
        .inst_exc      (inst_exc),
        .ctrl          (ctrl),
        .rd_tagv0      (rd_tagv0),
        .rd_tagv1      (rd_tagv1),
        .rd_line0      (rd_line0),
        .rd_line1      (rd_line1),
        .inst_index_ok (inst_index_ok),
        .inst_data_ok  (inst_data_ok),
        .inst_rdata    (inst_rdata),
        .rd_index      (rd_index),
        .sda           (sda),
        .sda_miss      (sda_miss)
    );

    icache_refill #(
        .AXI_ID (AXI_ID)
    ) u_refill (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .sda       (sda),
        .arready   (arready),
        .rid       (rid),
        .rdata     (rdata),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .rready    (rready),
        .fill      (fill),
        .fill_done (fill_done)
    );

    icache_lru u_lru (
        .clk    (clk),
        .rst    (rst),
        .ctrl   (ctrl),
        .index  (sda.index),
        .victim (victim)
    );

    icache_way_ram u_way0 (
        .clk      (clk),
        .rd_index (rd_index),
        .wen      (way_wen[0]),
        .wr_index (wr_index),
        .wr_tag   (wr_tag),
        .wr_valid (wr_valid),
        .wr_line  (fill.line),
        .rd_tagv  (rd_tagv0),
        .rd_line  (rd_line0)
    );

    icache_way_ram u_way1 (
        .clk      (clk),
        .rd_index (rd_index),
        .wen      (way_wen[1]),
        .wr_index (wr_index),
        .wr_tag   (wr_tag),
        .wr_valid (wr_valid),
        .wr_line  (fill.line),
        .rd_tagv  (rd_tagv1),
        .rd_line  (rd_line1)
    );

endmodule

// ==== dv/icache_assertions.sv ====
module icache_assertions (
    input logic                     clk,
    input logic                     rst,
    input logic                     arvalid,
    input logic                     arready,
    input logic                     rready,
    input logic                     inst_req,
    input logic                     inst_index_ok,
    input logic                     inst_data_ok
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [1:0] pending;
    logic [7:0] since_rst;

    // requests accepted and not yet completed
    always_ff @(posedge clk) begin
        if (!rst) begin
            pending <= '0;
        end else begin
            pending <= pending + 2'(inst_req && inst_index_ok) - 2'(inst_data_ok);
        end
    end

    // cycles since reset release, saturating
    always_ff @(posedge clk) begin
        if (!rst) begin
            since_rst <= '0;
        end else if (since_rst != '1) begin
            since_rst <= since_rst + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // AXI read address channel
    ////////////////////////////////////////////////////////////
    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    ar_r_excl: assert property (@(posedge clk) disable iff (!rst)
        !(rready && arvalid))
        else $error("rready and arvalid high together");

    // completion needs an accepted request still outstanding
    data_ok_valid: assert property (@(posedge clk) disable iff (!rst)
        inst_data_ok |-> (pending != 2'd0))
        else $error("inst_data_ok without an outstanding request");

    // quiet outputs while tags are invalidated and in the idle cycle after
    sweep_quiet: assert property (@(posedge clk) disable iff (!rst)
        (since_rst <= 8'(icache_pkg::NUM_SETS)) |->
            !inst_index_ok && !inst_data_ok && !arvalid && !rready)
        else $error("output active during the reset sweep");

endmodule

bind icache_top icache_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .arvalid       (arvalid),
    .arready       (arready),
    .rready        (rready),
    .inst_req      (inst_req),
    .inst_index_ok (inst_index_ok),
    .inst_data_ok  (inst_data_ok)
);

// ==== dv/icache_tb.sv ====
module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import icache_pkg::*;

    // sample point inside the low clock phase
    localparam int SAMPLE = 40;

    logic        clk;
    logic        rst;
    logic        inst_req;
    logic [7:0]  inst_index;
    logic [19:0] inst_tag;
    logic        inst_exc;
    logic [127:0] inst_rdata;
    logic        inst_index_ok;
    logic        inst_data_ok;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [3:0]  rid;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;

    logic [7:0]  stim_index [$];
    logic [19:0] stim_tag [$];
    int          stim_exc [$];
    int          stim_hit [$];
    logic        loaded;

    // reference cache contents
    logic [TAG_W-1:0] mdl_tag [NUM_WAYS][NUM_SETS];
    logic             mdl_valid [NUM_WAYS][NUM_SETS];
    logic             mdl_plru [NUM_SETS];

    // AXI slave state
    integer      seed;
    int          burst_cnt;
    logic [31:0] last_araddr;
    logic        burst_active;
    int          beat_no;

    icache_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .inst_req      (inst_req),
        .inst_index    (inst_index),
        .inst_tag      (inst_tag),
        .inst_exc      (inst_exc),
        .inst_rdata    (inst_rdata),
        .inst_index_ok (inst_index_ok),
        .inst_data_ok  (inst_data_ok),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rid           (rid),
        .rdata         (rdata),
        .rlast         (rlast),
        .rvalid        (rvalid),
        .rready        (rready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'h5A5A0000;
    endfunction

    // four words of a half line, lowest address in the low bits
    function automatic logic [127:0] expected_half(input logic [19:0] tg,
                                                   input logic [6:0] set, input logic half);
        logic [127:0] res;
        logic [31:0]  base;
        base = {tg, set, half, 4'b0000};
        for (int k = 0; k < 4; k++) begin
            res[32*k +: 32] = mem_word(base + 32'(4 * k));
        end
        return res;
    endfunction

    function automatic logic model_lookup(input logic [6:0] set, input logic [19:0] tg);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (mdl_valid[w][set] && mdl_tag[w][set] == tg) hit = 1'b1;
        end
        return hit;
    endfunction

    // plru names the way to replace, then flips to the other one
    function automatic void model_fill(input logic [6:0] set, input logic [19:0] tg);
        int w;
        w = mdl_plru[set] ? 1 : 0;
        mdl_tag[w][set]   = tg;
        mdl_valid[w][set] = 1'b1;
        mdl_plru[set]     = !mdl_plru[set];
    endfunction

    ////////////////////////////////////////////////////////////
    // AXI read slave, 8 wrapping beats with random gaps
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        int          r;
        logic [31:0] addr;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rid     = 4'h0;
        rdata   = '0;
        if (rst) begin
            if (arvalid && !burst_active) begin
                if ($random(seed) & 1) begin
                    arready      = 1'b1;
                    last_araddr  = araddr;
                    burst_active = 1'b1;
                    beat_no      = 0;
                    burst_cnt++;
                end
            end else if (burst_active && rready) begin
                r = $random(seed) & 3;
                if (r == 1) begin
                    // beat for another master
                    rvalid = 1'b1;
                    rid    = 4'h5;
                    rdata  = 32'hDEADBEEF;
                    rlast  = 1'b1;
                end else if (r != 0) begin
                    addr   = (last_araddr & ~32'h1F) | ((last_araddr + 32'(4 * beat_no)) & 32'h1F);
                    rvalid = 1'b1;
                    rdata  = mem_word(addr);
                    rlast  = (beat_no == BEATS - 1);
                    beat_no++;
                    if (beat_no == BEATS) burst_active = 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // request sequences
    ////////////////////////////////////////////////////////////
    task automatic run_request(input int n);
        logic [7:0]  ix;
        logic [19:0] tg;
        logic        ex;
        logic        hit_mdl;
        int          waits;
        int          lat;
        int          bursts;
        string       name;
        ix      = stim_index[n];
        tg      = stim_tag[n];
        ex      = (stim_exc[n] != 0);
        name    = $sformatf("req%0d", n);
        hit_mdl = model_lookup(ix[7:1], tg);
        if (!ex) check({name, " hit"}, 128'(stim_hit[n]), 128'(hit_mdl));
        inst_req   = 1'b1;
        inst_index = ix;
        waits      = 0;
        #SAMPLE;
        while (!inst_index_ok) begin
            @(negedge clk);
            waits++;
            #SAMPLE;
        end
        // sweep plus one idle cycle
        if (n == 0) check({name, " sweep wait"}, 128'(NUM_SETS + 1), 128'(waits));
        bursts = burst_cnt;
        @(negedge clk);
        inst_req = 1'b0;
        inst_tag = tg;
        inst_exc = ex;
        lat      = 1;
        #SAMPLE;
        while (!inst_data_ok) begin
            @(negedge clk);
            lat++;
            #SAMPLE;
        end
        if (ex || hit_mdl) begin
            check({name, " latency"}, 128'(2), 128'(lat));
            check({name, " bursts"}, 128'(bursts), 128'(burst_cnt));
        end else begin
            check({name, " bursts"}, 128'(bursts + 1), 128'(burst_cnt));
            check({name, " araddr"}, 128'({tg, ix, 4'b0000}), 128'(last_araddr));
            model_fill(ix[7:1], tg);
        end
        if (!ex) check({name, " data"}, expected_half(tg, ix[7:1], ix[0]), inst_rdata);
        @(negedge clk);
        inst_exc = 1'b0;
    endtask

    task automatic run_back_to_back(input logic [6:0] set, input logic [19:0] tg);
        int bursts;
        check("b2b resident", 128'(1), 128'(model_lookup(set, tg)));
        bursts     = burst_cnt;
        inst_req   = 1'b1;
        inst_index = {set, 1'b0};
        #SAMPLE;
        while (!inst_index_ok) begin
            @(negedge clk);
            #SAMPLE;
        end
        @(negedge clk);
        inst_index = {set, 1'b1};
        inst_tag   = tg;
        inst_exc   = 1'b0;
        #SAMPLE;
        check("b2b second accept", 128'(1), 128'(inst_index_ok));
        @(negedge clk);
        inst_req = 1'b0;
        #SAMPLE;
        check("b2b first done", 128'(1), 128'(inst_data_ok));
        check("b2b first data", expected_half(tg, set, 1'b0), inst_rdata);
        @(negedge clk);
        #SAMPLE;
        check("b2b second done", 128'(1), 128'(inst_data_ok));
        check("b2b second data", expected_half(tg, set, 1'b1), inst_rdata);
        check("b2b bursts", 128'(bursts), 128'(burst_cnt));
        @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        int          fd;
        string       line;
        logic [7:0]  ix;
        logic [19:0] tg;
        int          ex;
        int          hit;
        int          last;
        rst          = 1'b0;
        inst_req     = 1'b0;
        inst_index   = '0;
        inst_tag     = '0;
        inst_exc     = 1'b0;
        arready      = 1'b0;
        rid          = '0;
        rdata        = '0;
        rlast        = 1'b0;
        rvalid       = 1'b0;
        seed         = 16;
        burst_cnt    = 0;
        burst_active = 1'b0;
        beat_no      = 0;
        last_araddr  = '0;
        loaded       = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            mdl_valid[0][s] = 1'b0;
            mdl_valid[1][s] = 1'b0;
            mdl_plru[s]     = 1'b0;
        end
        fd = $fopen("dv/icache_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dv/icache_stim.txt");
            $display("Simulation failed");
            $fatal(1);
        end
        while ($fgets(line, fd)) begin
            if (line.len() > 2 && line[0] != "/") begin
                if ($sscanf(line, "%h %h %d %d", ix, tg, ex, hit) == 4) begin
                    stim_index.push_back(ix);
                    stim_tag.push_back(tg);
                    stim_exc.push_back(ex);
                    stim_hit.push_back(hit);
                end
            end
        end
        $fclose(fd);
        loaded = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b1;
        for (int n = 0; n < stim_index.size(); n++) begin
            run_request(n);
        end
        last = stim_index.size() - 1;
        run_back_to_back(stim_index[last][7:1], stim_tag[last]);
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (stim_index.size() * 60 + 400) @(posedge clk);
        $display("watchdog expired before all requests completed");
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

// ==== dv/icache_stim.txt ====
// columns: index byte {set, half} hex, tag hex, exception flag, expected hit
// set 0x20 holds tags 11111, 22222 and 33333 for the replacement check
00 12345 0 0
01 12345 0 1
00 12345 0 1
14 0abcd 0 0
15 0abcd 0 1
14 0abcd 1 0
14 0abcd 0 1
60 55555 1 0
60 55555 0 0
40 11111 0 0
41 22222 0 0
40 11111 0 1
41 22222 0 1
40 33333 0 0
41 22222 0 1
40 11111 0 0
41 33333 0 1
40 22222 0 0
7f 00001 0 0
7e 00001 0 1
ff fffff 0 0
fe fffff 0 1

// ==== filelist.f ====
common/icache_pkg.sv
icache/icache_way_ram.sv
icache/icache_lru.sv
icache/icache_refill.sv
icache/icache_pipe.sv
icache/icache_ctrl.sv
icache/icache_top.sv
dv/icache_assertions.sv
dv/icache_tb.sv

// ==== Makefile ====
TOP = icache_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
